/* compile.f */
verilog/av_test_pkg.sv
verilog/video_timing.sv
verilog/stripe_pattern.sv
verilog/i2s_serializer.sv
verilog/tone_osc.sv
verilog/av_test_top.sv
dv/av_test_tb.sv

/* dv/av_test_tb.sv */
// av test generator testbench
// runs the dut for a little over two video frames, models the raster and
// the i2s tone from the timing rules and checks every output against them

`timescale 1ns/1ps

module av_test_tb;

  localparam int t_reset  = 0;
  localparam int t_sync   = 1;
  localparam int t_window = 2;
  localparam int t_colour = 3;
  localparam int t_i2s    = 4;
  localparam int t_tone   = 5;
  localparam int n_tests  = 6;

  // raster as seen on the pins
  localparam int line_clks   = 400;
  localparam int frame_lines = 512;
  localparam int frame_clks  = line_clks * frame_lines;

  logic        audgen_mclk;
  logic        reset_n;
  logic [23:0] video_rgb;
  logic        video_de;
  logic        video_hs;
  logic        video_vs;
  logic        audio_sclk;
  logic        audio_lrck;
  logic        audio_dac;

  int    checks [n_tests] = '{0, 0, 0, 0, 0, 0};
  int    errs [n_tests] = '{0, 0, 0, 0, 0, 0};
  string test_name [n_tests] = '{"reset state", "sync spacing", "active window",
                                 "colour", "i2s framing", "tone"};

  // raster model and sync bookkeeping
  int cyc            = 0;
  bit model_on       = 1'b0;
  int mx             = 0;
  int my             = 0;
  int mframe         = 0;
  bit exp_de         = 1'b0;
  int vs_count       = 0;
  int last_vs_cyc    = 0;
  int last_hs_cyc    = -1;
  bit hs_pending     = 1'b0;
  int de_run         = 0;
  int lines_in_frame = 0;
  bit prev_de        = 1'b0;

  // i2s model
  bit prev_sclk       = 1'b0;
  bit prev_lrck       = 1'b0;
  bit prev_dac        = 1'b0;
  bit fell            = 1'b0;
  int last_rise_cyc   = -1;
  int falls_since_ws  = 0;
  int tb_bit          = 0;
  int slot_idx        = 0;

  av_test_top DUT (
    .audgen_mclk (audgen_mclk),
    .reset_n     (reset_n),
    .video_rgb   (video_rgb),
    .video_de    (video_de),
    .video_hs    (video_hs),
    .video_vs    (video_vs),
    .audio_sclk  (audio_sclk),
    .audio_lrck  (audio_lrck),
    .audio_dac   (audio_dac)
  );

  //////////////////////////////
  // check helpers
  //////////////////////////////

  task automatic check_value(input int test_id, input string sig, input int got, input int exp);
    checks[test_id] = checks[test_id] + 1;
    assert (got == exp) else begin
      errs[test_id] = errs[test_id] + 1;
      $display("error at %0d ns: %s got %0h expected %0h", $time, sig, got, exp);
    end
  endtask

  task automatic check_true(input int test_id, input bit cond, input string what);
    checks[test_id] = checks[test_id] + 1;
    assert (cond) else begin
      errs[test_id] = errs[test_id] + 1;
      $display("at %0d ns: %s", $time, what);
    end
  endtask

  // diagonal band rule with the sum kept to 10 bits then mod 12
  function automatic int expected_colour(input int f, input int px, input int py);
    int pos;
    pos = ((f + px + py) % 1024) % 12;
    if (pos < 4) begin
      return 32'h00ff0000;
    end else if (pos < 8) begin
      return 32'h0000ff00;
    end
    return 32'h000000ff;
  endfunction

  function automatic bit test_ok(input int i);
    return (errs[i] == 0) && (checks[i] > 0);
  endfunction

  task automatic report_test(input int i);
    $display("test %0d %s: %0d checks, %0d errors, %s", i, test_name[i], checks[i], errs[i],
             test_ok(i) ? "ok" : (checks[i] == 0 ? "no checks reached" : "failed"));
  endtask

  task automatic finish_run(input bit timed_out);
    int total_checks;
    int total_errs;
    int failed;
    total_checks = 0;
    total_errs   = 0;
    failed       = 0;
    for (int i = 1; i < n_tests; i++) begin
      report_test(i);
    end
    for (int i = 0; i < n_tests; i++) begin
      total_checks = total_checks + checks[i];
      total_errs   = total_errs + errs[i];
      if (!test_ok(i)) begin
        failed = failed + 1;
      end
    end
    $display("done: %0d tests, %0d failed, %0d checks, %0d errors",
             n_tests, failed, total_checks, total_errs);
    if (timed_out || failed > 0) begin
      $display("SIMULATION FAILED");
    end else begin
      $display("SIMULATION PASSED");
    end
    $finish;
  endtask

  //////////////////////////////
  // concurrent checks
  //////////////////////////////

  // syncs live in the porches
  assert property (@(posedge audgen_mclk) disable iff (!reset_n)
    video_de |-> !(video_hs || video_vs))
  else begin
    errs[t_window] = errs[t_window] + 1;
    $display("at %0d ns: data enable overlaps a sync pulse", $time);
  end

  // black whenever de is low
  assert property (@(posedge audgen_mclk) disable iff (!reset_n)
    !video_de |-> (video_rgb == 24'h000000))
  else begin
    errs[t_colour] = errs[t_colour] + 1;
    $display("at %0d ns: colour present outside the active window", $time);
  end

  //////////////////////////////
  // clock and stimulus
  //////////////////////////////

  initial begin
    audgen_mclk = 1'b0;
    forever #2 audgen_mclk = ~audgen_mclk;
  end

  initial begin
    bit timed_out;
    int waited;
    reset_n = 1'b0;
    waited  = 0;
    // every output held low through reset
    repeat (16) begin
      @(negedge audgen_mclk);
      check_value(t_reset, "video_rgb", int'(video_rgb), 0);
      check_value(t_reset, "video_de", int'(video_de), 0);
      check_value(t_reset, "video_hs", int'(video_hs), 0);
      check_value(t_reset, "video_vs", int'(video_vs), 0);
      check_value(t_reset, "audio_sclk", int'(audio_sclk), 0);
      check_value(t_reset, "audio_lrck", int'(audio_lrck), 0);
      check_value(t_reset, "audio_dac", int'(audio_dac), 0);
    end
    @(posedge audgen_mclk);
    #1 reset_n = 1'b1;
    // frame pulse on the very first edge after release
    @(posedge audgen_mclk);
    @(negedge audgen_mclk);
    check_value(t_reset, "video_vs", int'(video_vs), 1);
    report_test(t_reset);
    // two full frames need the third frame pulse
    while (vs_count < 3 && waited < 3 * frame_clks) begin
      @(negedge audgen_mclk);
      waited = waited + 1;
    end
    timed_out = (vs_count < 3);
    if (timed_out) begin
      $display("timeout: only %0d frame pulses after %0d cycles", vs_count, waited);
    end else begin
      repeat (600) @(negedge audgen_mclk);
    end
    finish_run(timed_out);
  end

  //////////////////////////////
  // monitors sampled mid cycle
  //////////////////////////////

  always @(negedge audgen_mclk) begin
    if (reset_n) begin
      cyc = cyc + 1;
      // raster model free runs once the first vs is seen
      if (model_on) begin
        if (mx == line_clks - 1) begin
          mx = 0;
          if (my == frame_lines - 1) begin
            my     = 0;
            mframe = (mframe + 1) % 1024;
          end else begin
            my = my + 1;
          end
        end else begin
          mx = mx + 1;
        end
      end else if (video_vs) begin
        model_on = 1'b1;
        mx       = 0;
        my       = 0;
        mframe   = 1;
      end
      if (model_on) begin
        exp_de = (mx >= 10) && (mx < 330) && (my >= 10) && (my < 250);
        check_value(t_sync, "video_vs", int'(video_vs), int'(mx == 0 && my == 0));
        check_value(t_sync, "video_hs", int'(video_hs), int'(mx == 3));
        check_value(t_window, "video_de", int'(video_de), int'(exp_de));
        check_value(t_colour, "video_rgb", int'(video_rgb),
                    exp_de ? expected_colour(mframe, mx, my) : 0);
      end

      // frame and line spacing
      if (video_vs) begin
        if (vs_count > 0) begin
          check_value(t_sync, "video_vs spacing", cyc - last_vs_cyc, frame_clks);
          check_value(t_window, "active lines per frame", lines_in_frame, 240);
        end
        vs_count       = vs_count + 1;
        last_vs_cyc    = cyc;
        lines_in_frame = 0;
        hs_pending     = 1'b1;
      end
      if (video_hs) begin
        if (hs_pending) begin
          check_value(t_sync, "video_hs after video_vs", cyc - last_vs_cyc, 3);
          hs_pending = 1'b0;
        end
        if (last_hs_cyc >= 0) begin
          check_value(t_sync, "video_hs spacing", cyc - last_hs_cyc, line_clks);
        end
        last_hs_cyc = cyc;
      end

      // de runs
      if (video_de && !prev_de) begin
        check_value(t_window, "video_de start after video_hs", cyc - last_hs_cyc, 7);
        de_run = 0;
      end
      if (video_de) begin
        de_run = de_run + 1;
      end
      if (!video_de && prev_de) begin
        check_value(t_window, "video_de run length", de_run, 320);
        lines_in_frame = lines_in_frame + 1;
      end

      // bit clock and word select
      fell = prev_sclk && !audio_sclk;
      if (!prev_sclk && audio_sclk) begin
        if (last_rise_cyc >= 0) begin
          check_value(t_i2s, "audio_sclk period", cyc - last_rise_cyc, 4);
        end
        last_rise_cyc = cyc;
      end
      if (audio_lrck != prev_lrck) begin
        check_true(t_i2s, fell, "audio_lrck changed away from a falling sclk edge");
      end
      if (audio_dac != prev_dac) begin
        check_true(t_i2s, fell, "audio_dac changed away from a falling sclk edge");
      end

      // slot model steps once per bit
      if (fell) begin
        falls_since_ws = falls_since_ws + 1;
        tb_bit         = (tb_bit + 1) % 32;
        if (tb_bit == 0) begin
          slot_idx = slot_idx + 1;
        end
        // word select flips on every 32nd fall and on no other
        check_value(t_i2s, "audio_lrck toggle", int'(audio_lrck != prev_lrck),
                    int'(falls_since_ws == 32));
        if (falls_since_ws == 32) begin
          falls_since_ws = 0;
        end
        // guard zeros, then the level of this half period
        check_value(t_tone, "audio_dac", int'(audio_dac),
                    (tb_bit < 4) ? 0 : (slot_idx / 109) % 2);
      end
    end
    prev_de   = video_de;
    prev_sclk = audio_sclk;
    prev_lrck = audio_lrck;
    prev_dac  = audio_dac;
  end

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the av test generator testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module av_test_tb \
  -f compile.f \
  -o av_test_sim

out=$(./obj_dir/av_test_sim)
echo "$out"

# the testbench reports its own verdict
if echo "$out" | grep -q "SIMULATION PASSED"; then
  exit 0
else
  exit 1
fi

/* verilog/av_test_pkg.sv */
// av test package
// raster, colour and i2s constants shared by the video and audio paths
// plus the width typedefs used across the design

package av_test_pkg;

  //////////////////////////////
  // raster timing
  //////////////////////////////

  // 400 clocks x 512 lines at 12.288 mhz gives 60 hz
  localparam int h_total  = 400;
  localparam int h_bporch = 10;
  localparam int h_active = 320;
  localparam int v_total  = 512;
  localparam int v_bporch = 10;
  localparam int v_active = 240;
  // line sync a few clocks after vs so the two never share a cycle
  localparam int hs_x     = 3;

  //////////////////////////////
  // stripe pattern
  //////////////////////////////

  localparam int stripe_period = 12;
  // three bands per period
  localparam int stripe_band   = 4;

  //////////////////////////////
  // i2s framing
  //////////////////////////////

  // bit clock is mclk / 4, 3.072 mhz
  localparam int sclk_div          = 4;
  localparam int slot_bits         = 32;
  localparam int guard_bits        = 4;
  // about 440 hz at 48 khz x 2 channels
  localparam int half_period_slots = 109;

  //////////////////////////////
  // types
  //////////////////////////////

  // x, y, frame and stripe sum
  typedef logic [9:0]  coord_t;
  // red in [23:16], green in [15:8], blue in [7:0]
  typedef logic [23:0] rgb_t;
  typedef logic [4:0]  slot_bit_t;
  typedef logic [6:0]  osc_count_t;

  // full intensity primaries
  localparam rgb_t rgb_black = 24'h000000;
  localparam rgb_t rgb_red   = 24'hff0000;
  localparam rgb_t rgb_green = 24'h00ff00;
  localparam rgb_t rgb_blue  = 24'h0000ff;

endpackage

/* verilog/av_test_top.sv */
// av test signal generator top
// video stripe pattern on a 320x240 raster and an i2s square wave tone,
// both running off the 12.288 mhz audio master clock

`timescale 1ns/1ps

module av_test_top (
  input  logic              audgen_mclk,
  input  logic              reset_n,
  output av_test_pkg::rgb_t video_rgb,
  output logic              video_de,
  output logic              video_hs,
  output logic              video_vs,
  output logic              audio_sclk,
  output logic              audio_lrck,
  output logic              audio_dac
);

  //////////////////////////////
  // video path
  //////////////////////////////

  av_test_pkg::coord_t x;
  av_test_pkg::coord_t y;
  av_test_pkg::coord_t frame;
  logic                active;

  video_timing u_video_timing (
    .audgen_mclk (audgen_mclk),
    .reset_n     (reset_n),
    .x           (x),
    .y           (y),
    .frame       (frame),
    .active      (active),
    .video_hs    (video_hs),
    .video_vs    (video_vs),
    .video_de    (video_de)
  );

  stripe_pattern u_stripe_pattern (
    .audgen_mclk (audgen_mclk),
    .reset_n     (reset_n),
    .x           (x),
    .y           (y),
    .frame       (frame),
    .active      (active),
    .video_rgb   (video_rgb)
  );

  //////////////////////////////
  // audio path
  //////////////////////////////

  // strobe out, level back
  logic slot_end;
  logic tone_high;

  i2s_serializer u_i2s_serializer (
    .audgen_mclk (audgen_mclk),
    .reset_n     (reset_n),
    .tone_high   (tone_high),
    .audio_sclk  (audio_sclk),
    .audio_lrck  (audio_lrck),
    .audio_dac   (audio_dac),
    .slot_end    (slot_end)
  );

  tone_osc u_tone_osc (
    .audgen_mclk (audgen_mclk),
    .reset_n     (reset_n),
    .slot_end    (slot_end),
    .tone_high   (tone_high)
  );

endmodule

/* verilog/i2s_serializer.sv */
// i2s serializer
// divides mclk by 4 into the bit clock and shifts out 32 bit slots,
// 4 guard zeros then the tone level, with word select per slot

`timescale 1ns/1ps

module i2s_serializer (
  input  logic audgen_mclk,
  input  logic reset_n,
  input  logic tone_high,
  output logic audio_sclk,
  output logic audio_lrck,
  output logic audio_dac,
  output logic slot_end
);

  localparam int div_w = $clog2(av_test_pkg::sclk_div);

  logic [div_w-1:0]       div;
  // sclk falling edge, a clock enable not a clock
  logic                   bit_stb;
  logic                   bit_last;
  av_test_pkg::slot_bit_t bit_idx;
  av_test_pkg::slot_bit_t bit_next;

  //////////////////////////////
  // bit clock divider
  //////////////////////////////

  always_ff @(posedge audgen_mclk or negedge reset_n) begin
    if (!reset_n) begin
      div <= '0;
    end else if (div == div_w'(av_test_pkg::sclk_div - 1)) begin
      div <= '0;
    end else begin
      div <= div + 1'b1;
    end
  end

  // low for 2 cycles, high for 2
  assign audio_sclk = div[1];
  // 3 -> 0 is the falling edge
  assign bit_stb    = (div == div_w'(av_test_pkg::sclk_div - 1));

  //////////////////////////////
  // slot framing
  //////////////////////////////

  assign bit_last = (bit_idx == av_test_pkg::slot_bits - 1);
  assign bit_next = bit_last ? '0 : bit_idx + 1'b1;
  // tone_osc counts these
  assign slot_end = bit_stb && bit_last;

  always_ff @(posedge audgen_mclk or negedge reset_n) begin
    if (!reset_n) begin
      bit_idx    <= '0;
      audio_lrck <= 1'b0;
      audio_dac  <= 1'b0;
    end else if (bit_stb) begin
      bit_idx <= bit_next;
      // switch channels as the slot wraps
      if (bit_last) begin
        audio_lrck <= ~audio_lrck;
      end
      // data for the bit now starting
      // guard zeros first, then the level
      if (bit_next < av_test_pkg::guard_bits) begin
        audio_dac <= 1'b0;
      end else begin
        audio_dac <= tone_high;
      end
    end
  end

  // guard bits stay zero whatever the tone level does
  assert property (@(posedge audgen_mclk) disable iff (!reset_n)
    (bit_idx < av_test_pkg::guard_bits) |-> !audio_dac);

endmodule

/* verilog/stripe_pattern.sv */
// stripe pattern generator
// moving red, green and blue diagonal bands over the active window

`timescale 1ns/1ps

module stripe_pattern (
  input  logic                audgen_mclk,
  input  logic                reset_n,
  input  av_test_pkg::coord_t x,
  input  av_test_pkg::coord_t y,
  input  av_test_pkg::coord_t frame,
  input  logic                active,
  output av_test_pkg::rgb_t   video_rgb
);

  av_test_pkg::coord_t stripe_sum;
  av_test_pkg::coord_t stripe_mod;
  av_test_pkg::rgb_t   colour;

  // diagonal position, low 10 bits only
  // frame term makes the bands crawl one pixel per frame
  assign stripe_sum = frame + x + y;
  assign stripe_mod = stripe_sum % av_test_pkg::coord_t'(av_test_pkg::stripe_period);

  //////////////////////////////
  // band select
  //////////////////////////////

  always_comb begin
    if (stripe_mod < av_test_pkg::stripe_band) begin
      colour = av_test_pkg::rgb_red;
    end else if (stripe_mod < 2 * av_test_pkg::stripe_band) begin
      colour = av_test_pkg::rgb_green;
    end else begin
      colour = av_test_pkg::rgb_blue;
    end
  end

  // black outside the window
  // lines up with video_de from the timing block
  always_ff @(posedge audgen_mclk or negedge reset_n) begin
    if (!reset_n) begin
      video_rgb <= av_test_pkg::rgb_black;
    end else if (active) begin
      video_rgb <= colour;
    end else begin
      video_rgb <= av_test_pkg::rgb_black;
    end
  end

  // only pure primaries ever leave this block
  assert property (@(posedge audgen_mclk) disable iff (!reset_n)
    (video_rgb != '0) |->
      $onehot({|video_rgb[23:16], |video_rgb[15:8], |video_rgb[7:0]}));

endmodule

/* verilog/tone_osc.sv */
// tone oscillator
// square wave level that flips every 109 i2s channel slots

`timescale 1ns/1ps

module tone_osc (
  input  logic audgen_mclk,
  input  logic reset_n,
  input  logic slot_end,
  output logic tone_high
);

  localparam av_test_pkg::osc_count_t half_count =
    av_test_pkg::osc_count_t'(av_test_pkg::half_period_slots);

  // slots seen in this half period, 1 based
  av_test_pkg::osc_count_t slot_cnt;

  //////////////////////////////
  // half period counter
  //////////////////////////////

  always_ff @(posedge audgen_mclk or negedge reset_n) begin
    if (!reset_n) begin
      slot_cnt  <= av_test_pkg::osc_count_t'(1);
      tone_high <= 1'b0;
    end else if (slot_end) begin
      if (slot_cnt == half_count) begin
        // end of half period, restart and flip
        slot_cnt  <= av_test_pkg::osc_count_t'(1);
        tone_high <= ~tone_high;
      end else begin
        slot_cnt <= slot_cnt + 1'b1;
      end
    end
  end

  // count range, never 0 and never past the half period
  assert property (@(posedge audgen_mclk) disable iff (!reset_n)
    (slot_cnt >= 1) && (slot_cnt <= half_count));

endmodule

/* verilog/video_timing.sv */
// video timing generator
// pixel and line counters for a 400 x 512 raster with a 320 x 240 window,
// registered sync pulses and data enable, and a running frame count

`timescale 1ns/1ps

module video_timing (
  input  logic                audgen_mclk,
  input  logic                reset_n,
  output av_test_pkg::coord_t x,
  output av_test_pkg::coord_t y,
  output av_test_pkg::coord_t frame,
  output logic                active,
  output logic                video_hs,
  output logic                video_vs,
  output logic                video_de
);

  // end of line / end of frame
  logic x_last;
  logic y_last;

  assign x_last = (x == av_test_pkg::h_total - 1);
  assign y_last = (y == av_test_pkg::v_total - 1);

  // inside the visible window, from the current counter state
  assign active = (x >= av_test_pkg::h_bporch) &&
                  (x <  av_test_pkg::h_bporch + av_test_pkg::h_active) &&
                  (y >= av_test_pkg::v_bporch) &&
                  (y <  av_test_pkg::v_bporch + av_test_pkg::v_active);

  //////////////////////////////
  // counters and sync
  //////////////////////////////

  always_ff @(posedge audgen_mclk or negedge reset_n) begin
    if (!reset_n) begin
      x        <= '0;
      y        <= '0;
      frame    <= '0;
      video_hs <= 1'b0;
      video_vs <= 1'b0;
      video_de <= 1'b0;
    end else begin
      // pixel counter, wraps at end of line
      if (x_last) begin
        x <= '0;
        // line counter, wraps at end of frame
        if (y_last) begin
          y <= '0;
        end else begin
          y <= y + 1'b1;
        end
      end else begin
        x <= x + 1'b1;
      end

      // new frame at the top left corner
      video_vs <= (x == '0) && (y == '0);
      if ((x == '0) && (y == '0)) begin
        frame <= frame + 1'b1;
      end

      // line sync in the back porch
      video_hs <= (x == av_test_pkg::hs_x);
      // same cycle as the stripe colour register
      video_de <= active;
    end
  end

  // syncs sit in the porch, never in the active area
  assert property (@(posedge audgen_mclk) disable iff (!reset_n)
    video_de |-> !(video_hs || video_vs));

  assert property (@(posedge audgen_mclk) disable iff (!reset_n)
    x < av_test_pkg::h_total);

endmodule
